//--- frame_store.sv
`timescale 1ns/1ps

module frame_store #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                clk_pixel,
  input  logic                pix_valid_i,
  input  vision_pkg::hcount_t pix_h_i,
  input  vision_pkg::vcount_t pix_v_i,
  input  vision_pkg::rgb565_t pix_data_i,
  input  vision_pkg::hcount_t hcount_i,
  input  vision_pkg::vcount_t vcount_i,
  output vision_pkg::rgb888_t pixel_o
);
  import vision_pkg::*;

  localparam int FB_W     = H_ACTIVE >> SCALE_SHIFT;
  localparam int FB_H     = V_ACTIVE >> SCALE_SHIFT;
  localparam int FB_DEPTH = FB_W * FB_H;
  localparam int ADDR_W   = $clog2(FB_DEPTH);
  localparam logic [ADDR_W-1:0] FB_W_A    = ADDR_W'(FB_W);
  localparam logic [ADDR_W-1:0] LAST_COL  = ADDR_W'(FB_W - 1);

  rgb565_t mem [FB_DEPTH];  // down-sampled image, row major

  logic              wr_en_q;
  logic [ADDR_W-1:0] wr_addr_q;
  rgb565_t           wr_data_q;
  logic [ADDR_W-1:0] rd_col;
  logic [ADDR_W-1:0] rd_row;
  logic [ADDR_W-1:0] rd_addr_q;
  rgb565_t           rd_data_q;
  logic [1:0]        good_q;    // in-image flag riding with the read

  // stream side, registered address then write, out of range dropped
  always_ff @(posedge clk_pixel) begin
    wr_en_q   <= pix_valid_i && (pix_h_i < hcount_t'(FB_W)) && (pix_v_i < vcount_t'(FB_H));
    wr_addr_q <= ADDR_W'(pix_h_i) + FB_W_A * ADDR_W'(pix_v_i);
    wr_data_q <= pix_data_i;
    if (wr_en_q) begin
      mem[wr_addr_q] <= wr_data_q;
    end
  end

  // mirrored column, quartered row and column
  assign rd_col = LAST_COL - ADDR_W'(hcount_i >> SCALE_SHIFT);
  assign rd_row = ADDR_W'(vcount_i >> SCALE_SHIFT);

  // stage 1 address, stage 2 memory
  always_ff @(posedge clk_pixel) begin
    rd_addr_q <= rd_col + FB_W_A * rd_row;
    good_q[0] <= (hcount_i < hcount_t'(H_ACTIVE)) && (vcount_i < vcount_t'(V_ACTIVE));
    rd_data_q <= mem[rd_addr_q];
    good_q[1] <= good_q[0];
  end

  // stage 3 unpack, zero low bits per channel, black outside the image
  always_ff @(posedge clk_pixel) begin
    if (good_q[1]) begin
      pixel_o <= {rd_data_q[15:11], 3'b000,   // red 5 -> 8
                  rd_data_q[10:5], 2'b00,     // green 6 -> 8
                  rd_data_q[4:0], 3'b000};    // blue 5 -> 8
    end else begin
      pixel_o <= '0;
    end
  end

endmodule

//--- key_display_top.sv
`timescale 1ns/1ps

module key_display_top #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [7:0]          paddr_i,
  input  logic [31:0]         pwdata_i,
  output logic [31:0]         prdata_o,
  input  logic                pix_valid_i,
  input  vision_pkg::hcount_t pix_h_i,
  input  vision_pkg::vcount_t pix_v_i,
  input  vision_pkg::rgb565_t pix_data_i,
  output vision_pkg::rgb888_t rgb_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                de_o
);
  import vision_pkg::*;

  hcount_t       hcount;     // raster, before the pipeline
  vcount_t       vcount;
  logic          hsync;
  logic          vsync;
  logic          de;
  overlay_mode_t mode;
  logic [NUM_KEY_LINES-1:0]  key_en;
  key_x_t [NUM_KEY_LINES-1:0] key_x;
  hcount_t [NUM_CENTROIDS-1:0] cent_x;
  vcount_t [NUM_CENTROIDS-1:0] cent_y;
  rgb888_t       pixel_rgb;  // 3 cycles behind hcount/vcount

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .hcount_o(hcount), .vcount_o(vcount),
    .hsync_o(hsync), .vsync_o(vsync), .de_o(de),
    .new_frame_o()  // no frame-rate consumer here
  );

  overlay_regs #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_regs (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .mode_o(mode), .key_en_o(key_en), .key_x_o(key_x),
    .cent_x_o(cent_x), .cent_y_o(cent_y)
  );

  frame_store #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_store (
    .clk_pixel(clk_pixel),
    .pix_valid_i(pix_valid_i), .pix_h_i(pix_h_i), .pix_v_i(pix_v_i),
    .pix_data_i(pix_data_i),
    .hcount_i(hcount), .vcount_i(vcount), .pixel_o(pixel_rgb)
  );

  overlay_mixer #(.H_ACTIVE(H_ACTIVE)) u_mixer (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .hcount_i(hcount), .vcount_i(vcount),
    .hsync_i(hsync), .vsync_i(vsync), .de_i(de),
    .mode_i(mode), .key_en_i(key_en), .key_x_i(key_x),
    .cent_x_i(cent_x), .cent_y_i(cent_y), .pixel_i(pixel_rgb),
    .rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
  );

endmodule

//--- overlay_mixer.sv
`timescale 1ns/1ps

module overlay_mixer #(
  parameter int H_ACTIVE = 1280
) (
  input  logic                      clk_pixel,
  input  logic                      recent_reset,
  input  vision_pkg::hcount_t       hcount_i,
  input  vision_pkg::vcount_t       vcount_i,
  input  logic                      hsync_i,
  input  logic                      vsync_i,
  input  logic                      de_i,
  input  vision_pkg::overlay_mode_t mode_i,
  input  logic [vision_pkg::NUM_KEY_LINES-1:0] key_en_i,
  input  vision_pkg::key_x_t [vision_pkg::NUM_KEY_LINES-1:0] key_x_i,
  input  vision_pkg::hcount_t [vision_pkg::NUM_CENTROIDS-1:0] cent_x_i,
  input  vision_pkg::vcount_t [vision_pkg::NUM_CENTROIDS-1:0] cent_y_i,
  input  vision_pkg::rgb888_t       pixel_i,
  output vision_pkg::rgb888_t       rgb_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      de_o
);
  import vision_pkg::*;

  localparam hcount_t RIGHT_COL = hcount_t'(H_ACTIVE - 1);  // mirror pivot
  localparam rgb888_t WHITE     = 24'hFF_FFFF;

  logic       key_hit;
  logic       cross_hit;
  logic       hit;
  logic [2:0] hit_q;   // matches frame store latency
  logic [2:0] hs_q;
  logic [2:0] vs_q;
  logic [2:0] de_q;

  always_comb begin
    key_hit   = 1'b0;
    cross_hit = 1'b0;
    // key lines live in mirrored frame store columns
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      if (key_en_i[i] && hcount_i == RIGHT_COL - (hcount_t'(key_x_i[i]) << SCALE_SHIFT)) begin
        key_hit = 1'b1;
      end
    end
    // full column and full row per centroid
    for (int i = 0; i < NUM_CENTROIDS; i++) begin
      if (hcount_i == cent_x_i[i] || vcount_i == cent_y_i[i]) begin
        cross_hit = 1'b1;
      end
    end
    unique case (mode_i)
      OVL_KEYS:  hit = key_hit;
      OVL_CROSS: hit = cross_hit;
      OVL_BOTH:  hit = key_hit | cross_hit;
      default:   hit = 1'b0;
    endcase
    hit = hit & de_i;  // blanking stays black
  end

  // three stage delay, lines up with pixel_i
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hit_q <= '0;
      hs_q  <= '0;
      vs_q  <= '0;
      de_q  <= '0;
    end else begin
      hit_q <= {hit_q[1:0], hit};
      hs_q  <= {hs_q[1:0], hsync_i};
      vs_q  <= {vs_q[1:0], vsync_i};
      de_q  <= {de_q[1:0], de_i};
    end
  end

  // output stage, syncs keep low until the pipe has filled
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
    end else begin
      hsync_o <= hs_q[2];
      vsync_o <= vs_q[2];
      de_o    <= de_q[2];
    end
    rgb_o <= hit_q[2] ? WHITE : pixel_i;  // overlay wins over the image
  end

endmodule

//--- overlay_regs.sv
`timescale 1ns/1ps

module overlay_regs #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                       clk_pixel,
  input  logic                       recent_reset,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [7:0]                 paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output vision_pkg::overlay_mode_t  mode_o,
  output logic [vision_pkg::NUM_KEY_LINES-1:0] key_en_o,
  output vision_pkg::key_x_t [vision_pkg::NUM_KEY_LINES-1:0] key_x_o,
  output vision_pkg::hcount_t [vision_pkg::NUM_CENTROIDS-1:0] cent_x_o,
  output vision_pkg::vcount_t [vision_pkg::NUM_CENTROIDS-1:0] cent_y_o
);
  import vision_pkg::*;

  logic       access;    // access phase of any transfer
  logic       wr_en;
  logic [7:0] key_off;
  logic [7:0] cent_off;
  logic [3:0] key_idx;
  logic [1:0] cent_idx;
  logic       mode_sel;
  logic       key_sel;
  logic       cent_sel;
  apb_word_u  wr_u;      // incoming word, decoded per window
  apb_word_u  rd_u;      // outgoing key or centroid word
  logic [31:0] rd_word;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;
  assign wr_u   = pwdata_i;

  // address windows, word aligned only
  assign key_off  = paddr_i - REG_KEY_BASE;
  assign cent_off = paddr_i - REG_CENT_BASE;
  assign key_idx  = key_off[5:2];
  assign cent_idx = cent_off[3:2];
  assign mode_sel = (paddr_i == REG_MODE);
  assign key_sel  = (paddr_i >= REG_KEY_BASE) && (key_off < 8'(4 * NUM_KEY_LINES)) &&
                    (paddr_i[1:0] == 2'b00);
  assign cent_sel = (paddr_i >= REG_CENT_BASE) && (cent_off < 8'(4 * NUM_CENTROIDS)) &&
                    (paddr_i[1:0] == 2'b00);

  // write takes effect at the end of the access phase
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      mode_o   <= OVL_NONE;
      key_en_o <= '0;
      key_x_o  <= '0;
      for (int i = 0; i < NUM_CENTROIDS; i++) begin
        cent_x_o[i] <= hcount_t'((i + 1) * H_ACTIVE / 4);  // spread across the width
        cent_y_o[i] <= vcount_t'(V_ACTIVE / 2);            // mid height
      end
    end else if (wr_en) begin
      if (mode_sel) mode_o <= overlay_mode_t'(pwdata_i[1:0]);
      for (int i = 0; i < NUM_KEY_LINES; i++) begin
        if (key_sel && key_idx == i) begin
          key_en_o[i] <= wr_u.key.en;
          key_x_o[i]  <= wr_u.key.x;
        end
      end
      for (int i = 0; i < NUM_CENTROIDS; i++) begin
        if (cent_sel && cent_idx == i) begin
          cent_x_o[i] <= wr_u.cent.x;
          cent_y_o[i] <= wr_u.cent.y;
        end
      end
    end
  end

  // read mux, unused bits and unmapped addresses give zero
  always_comb begin
    rd_u    = '0;
    rd_word = '0;
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      if (key_sel && key_idx == i) begin
        rd_u.key.en = key_en_o[i];
        rd_u.key.x  = key_x_o[i];
      end
    end
    for (int i = 0; i < NUM_CENTROIDS; i++) begin
      if (cent_sel && cent_idx == i) begin
        rd_u.cent.x = cent_x_o[i];
        rd_u.cent.y = cent_y_o[i];
      end
    end
    if (mode_sel) rd_word = 32'(mode_o);
    else if (key_sel || cent_sel) rd_word = rd_u;
  end

  assign prdata_o = (access && !pwrite_i) ? rd_word : '0;  // no wait states

endmodule

//--- tb_key_display.sv
`timescale 1ns/1ps

module tb_key_display;
  import vision_pkg::*;

  localparam int H_ACTIVE     = 64;
  localparam int H_FRONT      = 4;
  localparam int H_SYNC       = 4;
  localparam int H_BACK       = 4;
  localparam int V_ACTIVE     = 16;
  localparam int V_FRONT      = 2;
  localparam int V_SYNC       = 2;
  localparam int V_BACK       = 2;
  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
  localparam int FB_W         = H_ACTIVE / 4;
  localparam int WATCHDOG_NS  = (6 * FRAME_CYCLES + 400) * 4;  // six frames plus setup

  logic        clk_pixel = 1'b0;
  logic        recent_reset;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pix_valid_i;
  hcount_t     pix_h_i;
  vcount_t     pix_v_i;
  rgb565_t     pix_data_i;
  rgb888_t     rgb_o;
  logic        hsync_o;
  logic        vsync_o;
  logic        de_o;

  // reference model state
  rgb565_t       fb_model [0:FB_W*(V_ACTIVE/4)-1];
  overlay_mode_t mode_m;
  logic          key_en_m [0:NUM_KEY_LINES-1];
  key_x_t        key_x_m [0:NUM_KEY_LINES-1];
  hcount_t       cent_x_m [0:NUM_CENTROIDS-1];
  vcount_t       cent_y_m [0:NUM_CENTROIDS-1];
  logic [31:0]   rng = 32'd43;

  // output raster tracking
  int      col = 0;
  int      row = 0;
  int      hs_len = 0;
  int      vs_len = 0;
  int      checked = 0;
  logic    check_on = 1'b0;
  rgb888_t exp_rgb;
  int      raster_errs = 0;
  int      reg_errs = 0;
  int      pix_errs = 0;

  key_display_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) UUT (.*);

  always #2 clk_pixel = ~clk_pixel;  // 4 ns pixel clock

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // colour the display should show at active position (h, v)
  function automatic rgb888_t expected_pixel(input int h, input int v);
    rgb565_t w;
    logic    key_hit;
    logic    cross_hit;
    logic    white;
    key_hit   = 1'b0;
    cross_hit = 1'b0;
    w = fb_model[(FB_W - 1 - h / 4) + FB_W * (v / 4)];  // mirrored, quartered
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      key_hit |= key_en_m[i] && (h == H_ACTIVE - 1 - 4 * key_x_m[i]);
    end
    for (int i = 0; i < NUM_CENTROIDS; i++) begin
      cross_hit |= (h == cent_x_m[i]) || (v == cent_y_m[i]);
    end
    case (mode_m)
      OVL_KEYS:  white = key_hit;
      OVL_CROSS: white = cross_hit;
      OVL_BOTH:  white = key_hit | cross_hit;
      default:   white = 1'b0;
    endcase
    return white ? 24'hFF_FFFF : {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
  endfunction

  // one APB transfer, setup then access, no wait states
  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
    @(negedge clk_pixel);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_pixel);
    penable_i = 1'b1;
    @(posedge clk_pixel);
    rdata = prdata_o;  // combinational during access
    @(negedge clk_pixel);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] got;
    apb_transfer(1'b0, addr, 32'd0, got);
    assert (got == expected) else begin
      reg_errs++;
      $display("Error: %0t ns read of 0x%02h gave 0x%08h, expected 0x%08h",
               $time, addr, got, expected);
    end
  endtask

  task automatic set_key(input int i, input logic en, input key_x_t x);
    logic [31:0] word;
    logic [31:0] unused;
    rng = xorshift32(rng);
    word = rng;  // junk in the padding bits
    word[31] = en;
    word[8:0] = x;
    apb_transfer(1'b1, 8'(REG_KEY_BASE + 4 * i), word, unused);
    key_en_m[i] = en;
    key_x_m[i]  = x;
    read_check(8'(REG_KEY_BASE + 4 * i), {en, 22'd0, x});
  endtask

  task automatic set_cent(input int i, input hcount_t x, input vcount_t y);
    logic [31:0] word;
    logic [31:0] unused;
    rng = xorshift32(rng);
    word = rng;
    word[20:0] = {y, x};  // y in 20:11, x in 10:0
    apb_transfer(1'b1, 8'(REG_CENT_BASE + 4 * i), word, unused);
    cent_x_m[i] = x;
    cent_y_m[i] = y;
    read_check(8'(REG_CENT_BASE + 4 * i), {11'd0, y, x});
  endtask

  // fill the frame store with random words, then two out of range writes
  task automatic stream_frame();
    for (int v = 0; v < V_ACTIVE / 4; v++) begin
      for (int h = 0; h < FB_W; h++) begin
        @(negedge clk_pixel);
        rng = xorshift32(rng);
        pix_valid_i = 1'b1;
        pix_h_i     = hcount_t'(h);
        pix_v_i     = vcount_t'(v);
        pix_data_i  = rng[15:0];
        fb_model[h + FB_W * v] = rng[15:0];
      end
    end
    @(negedge clk_pixel);
    pix_h_i    = hcount_t'(FB_W);  // would alias to (0,1) if not dropped
    pix_v_i    = '0;
    pix_data_i = 16'hDEAD;
    @(negedge clk_pixel);
    pix_h_i = hcount_t'(FB_W + 4);
    pix_v_i = vcount_t'(1);
    @(negedge clk_pixel);
    pix_valid_i = 1'b0;
  endtask

  // called just after a vsync_o edge, mode change lands in blanking
  task automatic check_frame(input overlay_mode_t mode);
    logic [31:0] unused;
    apb_transfer(1'b1, REG_MODE, 32'(mode), unused);
    mode_m = mode;
    read_check(REG_MODE, 32'(mode));
    checked  = 0;
    check_on = 1'b1;
    @(posedge vsync_o);
    check_on = 1'b0;
    assert (checked == H_ACTIVE * V_ACTIVE) else begin
      pix_errs++;
      $display("Frame in mode %0d compared %0d pixels, not a whole frame", mode, checked);
    end
  endtask

  // monitor, mid cycle so the registered outputs are settled
  always @(negedge clk_pixel) begin
    if (de_o) begin
      if (check_on) begin
        exp_rgb = expected_pixel(col, row);
        checked++;
        assert (rgb_o == exp_rgb) else begin
          pix_errs++;
          $display("Error: %0t ns pixel (%0d,%0d) is %06h, expected %06h",
                   $time, col, row, rgb_o, exp_rgb);
        end
      end
      col++;
    end else if (col != 0) begin  // end of an active line
      assert (col == H_ACTIVE) else begin
        raster_errs++;
        $display("Error: %0t ns line %0d had %0d de cycles, expected %0d",
                 $time, row, col, H_ACTIVE);
      end
      col = 0;
      row++;
    end
    if (check_on && !de_o) begin  // nothing is drawn in blanking
      assert (rgb_o == '0) else begin
        pix_errs++;
        $display("Error: %0t ns blanking pixel is %06h, expected 000000", $time, rgb_o);
      end
    end
    if (hsync_o) hs_len++;
    else if (hs_len != 0) begin
      assert (hs_len == H_SYNC) else begin
        raster_errs++;
        $display("Error: %0t ns hsync pulse of %0d cycles, expected %0d", $time, hs_len, H_SYNC);
      end
      hs_len = 0;
    end
    if (vsync_o) begin
      if (vs_len == 0) begin  // frame boundary
        assert (row == V_ACTIVE) else begin
          raster_errs++;
          $display("Error: %0t ns frame had %0d de lines, expected %0d", $time, row, V_ACTIVE);
        end
        row = 0;
      end
      vs_len++;
    end else if (vs_len != 0) begin
      assert (vs_len == V_SYNC * H_TOTAL) else begin
        raster_errs++;
        $display("Error: %0t ns vsync pulse of %0d cycles, expected %0d",
                 $time, vs_len, V_SYNC * H_TOTAL);
      end
      vs_len = 0;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the test sequence did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    pix_valid_i  = 1'b0;
    pix_h_i      = '0;
    pix_v_i      = '0;
    pix_data_i   = '0;
    mode_m       = OVL_NONE;
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      key_en_m[i] = 1'b0;
      key_x_m[i]  = '0;
    end
    for (int i = 0; i < NUM_CENTROIDS; i++) begin
      cent_x_m[i] = hcount_t'((i + 1) * H_ACTIVE / 4);  // reset defaults
      cent_y_m[i] = vcount_t'(V_ACTIVE / 2);
    end
    recent_reset = 1'b1;
    repeat (5) @(negedge clk_pixel);
    recent_reset = 1'b0;

    // register file after reset, plus two holes in the map
    read_check(REG_MODE, 32'd0);
    read_check(8'h08, 32'd0);
    read_check(8'h5C, 32'd0);
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      read_check(8'(REG_KEY_BASE + 4 * i), 32'd0);
    end
    for (int i = 0; i < NUM_CENTROIDS; i++) begin
      read_check(8'(REG_CENT_BASE + 4 * i), {11'd0, cent_y_m[i], cent_x_m[i]});
    end

    stream_frame();
    for (int i = 0; i < NUM_KEY_LINES; i++) begin
      set_key(i, (i % 2) == 0, key_x_t'(i));  // odd lines stay disabled
    end
    set_cent(0, hcount_t'(5), vcount_t'(3));
    set_cent(1, hcount_t'(22), vcount_t'(9));
    set_cent(2, hcount_t'(41), vcount_t'(14));

    @(posedge vsync_o);
    check_frame(OVL_NONE);
    check_frame(OVL_KEYS);
    check_frame(OVL_CROSS);
    check_frame(OVL_BOTH);

    $display("errors: raster %0d, register %0d, pixel %0d", raster_errs, reg_errs, pix_errs);
    if (raster_errs + reg_errs + pix_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
vision_pkg.sv
video_timing.sv
overlay_regs.sv
frame_store.sv
overlay_mixer.sv
key_display_top.sv
tb_key_display.sv

//--- video_timing.sv
`timescale 1ns/1ps

module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic              clk_pixel,
  input  logic              recent_reset,
  output vision_pkg::hcount_t hcount_o,
  output vision_pkg::vcount_t vcount_o,
  output logic              hsync_o,
  output logic              vsync_o,
  output logic              de_o,
  output logic              new_frame_o
);
  import vision_pkg::*;

  localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START  = H_ACTIVE + H_FRONT;  // first sync column
  localparam int VS_START  = V_ACTIVE + V_FRONT;  // first sync line

  hcount_t h_q;
  vcount_t v_q;

  // free running raster, h wraps into v
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      h_q <= '0;
      v_q <= '0;
    end else if (h_q == hcount_t'(H_TOTAL - 1)) begin
      h_q <= '0;
      if (v_q == vcount_t'(V_TOTAL - 1)) begin
        v_q <= '0;  // back to top of frame
      end else begin
        v_q <= v_q + 1'b1;
      end
    end else begin
      h_q <= h_q + 1'b1;
    end
  end

  assign hcount_o = h_q;
  assign vcount_o = v_q;

  // decodes are same cycle as the counters
  assign hsync_o = (h_q >= hcount_t'(HS_START)) && (h_q < hcount_t'(HS_START + H_SYNC));
  assign vsync_o = (v_q >= vcount_t'(VS_START)) && (v_q < vcount_t'(VS_START + V_SYNC));
  assign de_o    = (h_q < hcount_t'(H_ACTIVE)) && (v_q < vcount_t'(V_ACTIVE));

  // one cycle pulse, first blanking pixel below the image
  assign new_frame_o = (h_q == hcount_t'(H_ACTIVE)) && (v_q == vcount_t'(V_ACTIVE));

endmodule

//--- vision_pkg.sv
package vision_pkg;

  // raster and pixel widths
  typedef logic [10:0] hcount_t;  // up to 2047 columns incl. blanking
  typedef logic [9:0]  vcount_t;  // up to 1023 lines incl. blanking
  typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]
  typedef logic [23:0] rgb888_t;  // r[23:16] g[15:8] b[7:0]
  typedef logic [8:0]  key_x_t;   // key boundary x, frame store units

  localparam int NUM_KEY_LINES = 13;  // top edge boundaries
  localparam int NUM_CENTROIDS = 3;   // thumb, middle, pinky
  localparam int SCALE_SHIFT   = 2;   // 4x upscale

  // APB register map, byte offsets
  localparam logic [7:0] REG_MODE      = 8'h00;
  localparam logic [7:0] REG_KEY_BASE  = 8'h10;  // 13 words
  localparam logic [7:0] REG_CENT_BASE = 8'h50;  // 3 words

  typedef enum logic [1:0] {
    OVL_NONE  = 2'd0,  // image only
    OVL_KEYS  = 2'd1,  // key boundary lines
    OVL_CROSS = 2'd2,  // centroid crosshairs
    OVL_BOTH  = 2'd3
  } overlay_mode_t;

  // data word as seen in the key window
  typedef struct packed {
    logic        en;   // bit 31
    logic [21:0] pad;
    key_x_t      x;    // bits 8:0
  } key_word_t;

  // data word as seen in the centroid window
  typedef struct packed {
    logic [10:0] pad;
    vcount_t     y;    // bits 20:11
    hcount_t     x;    // bits 10:0
  } centroid_word_t;

  // one APB data word, decoded by address window
  typedef union packed {
    key_word_t      key;
    centroid_word_t cent;
  } apb_word_u;

endpackage
